//--- hw/eth_cfg.svh
`ifndef ETH_CFG_SVH
`define ETH_CFG_SVH

// Byte-address width of each frame buffer, 64 bytes
`define ETH_BUF_W 6

// PHY reset hold time in clk_i cycles
// Short count for simulation runs, a board build wants 100000 here
`define ETH_PHY_RST_CNT 20

// Width of the PHY reset down-counter, holds the board count too
`define ETH_PHY_RST_W 17

`endif

//--- hw/eth_pkg.sv
package eth_pkg;

  // Wishbone byte offsets
  localparam logic [8:0] REG_TX_CTRL  = 9'h000;
  localparam logic [8:0] REG_RX_STAT  = 9'h004;
  localparam logic [8:0] REG_PHY_STAT = 9'h008;
  localparam logic [8:0] REG_BUF_BASE = 9'h100; // Buffer window, one byte per word

  localparam logic [3:0] PREAMBLE_NIB = 4'h5;
  localparam logic [3:0] SFD_NIB      = 4'hD; // Upper nibble of the SFD byte

  localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
  localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320; // Reflected form
  // Good-frame residue, MSB-first bit order
  localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_PREAMBLE,
    TX_DATA,
    TX_FCS
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PREAMBLE,
    RX_DATA,
    RX_DONE     // Drain until dv drops
  } rx_state_e;

  // One MII nibble through the reflected CRC-32, bit 0 first
  function automatic logic [31:0] crc32_nibble(input logic [31:0] crc, input logic [3:0] nib);
    logic [31:0] c;
    c = crc ^ {28'h0, nib};
    for (int i = 0; i < 4; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

endpackage

//--- hw/eth_if.sv
`timescale 1ns/100ps
`include "eth_cfg.svh"

// Register file to transmitter
interface eth_tx_if ();
  logic                 send;    // Single-cycle pulse
  logic                 crc_en;
  logic [`ETH_BUF_W:0]  nbytes;
  logic [7:0]           rd_data; // One cycle behind rd_addr
  logic                 ready;
  logic [`ETH_BUF_W-1:0] rd_addr;

  modport regs (output send, crc_en, nbytes, rd_data, input ready, rd_addr);
  modport tx (input send, crc_en, nbytes, rd_data, output ready, rd_addr);
endinterface

// Receiver to register file
interface eth_rx_if ();
  logic                  wr;
  logic [`ETH_BUF_W-1:0] addr;
  logic [7:0]            data;
  logic                  done;    // Single-cycle pulse at end of frame
  logic [`ETH_BUF_W:0]   nbytes;
  logic                  crc_err;
  logic                  busy;    // Previous frame not yet acknowledged

  modport regs (input wr, addr, data, done, nbytes, crc_err, output busy);
  modport rx (output wr, addr, data, done, nbytes, crc_err, input busy);
endinterface

//--- hw/eth_wb_regs.sv
`timescale 1ns/100ps
`include "eth_cfg.svh"

module eth_wb_regs (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [8:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        inta_o,
  input  logic        phy_rst_i,
  eth_tx_if.regs      tx_if,
  eth_rx_if.regs      rx_if
);

  logic [7:0] tx_buf [2**`ETH_BUF_W];
  logic [7:0] rx_buf [2**`ETH_BUF_W];

  logic                  req;
  logic                  wr_req;
  logic                  ctrl_sel;
  logic                  stat_sel;
  logic                  phy_sel;
  logic                  buf_sel;
  logic [`ETH_BUF_W-1:0] buf_idx;
  logic [31:0]           rd_word;

  logic                  send_q;
  logic                  crc_en_q;
  logic [`ETH_BUF_W:0]   nbytes_q;
  logic                  rcvd_q;     // Frame waiting for the host
  logic                  crc_err_q;
  logic [`ETH_BUF_W:0]   rx_nbytes_q;
  logic [7:0]            tx_rd_q;

  // New strobe only, so every access gets a single ack
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_req = req & wb_we_i;

  assign ctrl_sel = (wb_adr_i == eth_pkg::REG_TX_CTRL);
  assign stat_sel = (wb_adr_i == eth_pkg::REG_RX_STAT);
  assign phy_sel  = (wb_adr_i == eth_pkg::REG_PHY_STAT);
  assign buf_sel  = (wb_adr_i >= eth_pkg::REG_BUF_BASE);
  assign buf_idx  = wb_adr_i[`ETH_BUF_W+1:2]; // Word index in the window

  always_comb begin
    rd_word = '0;
    if (ctrl_sel) begin
      rd_word[0] = tx_if.ready;
    end else if (stat_sel) begin
      rd_word[0] = rcvd_q;
      rd_word[1] = crc_err_q;
      rd_word[16 +: `ETH_BUF_W+1] = rx_nbytes_q;
    end else if (phy_sel) begin
      rd_word[0] = phy_rst_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o    <= 1'b0;
      send_q      <= 1'b0;
      crc_en_q    <= 1'b0;
      nbytes_q    <= '0;
      rcvd_q      <= 1'b0;
      crc_err_q   <= 1'b0;
      rx_nbytes_q <= '0;
    end else begin
      wb_ack_o <= req;
      send_q   <= wr_req & ctrl_sel & wb_dat_i[0];
      if (wr_req && ctrl_sel) begin
        crc_en_q <= wb_dat_i[1];
        nbytes_q <= wb_dat_i[16 +: `ETH_BUF_W+1];
      end
      if (rx_if.done) begin // Set wins over a same-cycle acknowledge
        rcvd_q      <= 1'b1;
        crc_err_q   <= rx_if.crc_err;
        rx_nbytes_q <= rx_if.nbytes;
      end else if (wr_req && stat_sel) begin
        rcvd_q <= 1'b0;
      end
    end
  end

  // Read data lands with the ack
  always_ff @(posedge clk_i) begin
    if (req && !wb_we_i) begin
      wb_dat_o <= buf_sel ? {24'h0, rx_buf[buf_idx]} : rd_word;
    end
  end

  // Tx buffer, host writes and transmitter reads
  always_ff @(posedge clk_i) begin
    if (wr_req && buf_sel) begin
      tx_buf[buf_idx] <= wb_dat_i[7:0];
    end
    tx_rd_q <= tx_buf[tx_if.rd_addr];
  end

  // Rx buffer, receiver writes
  always_ff @(posedge clk_i) begin
    if (rx_if.wr) begin
      rx_buf[rx_if.addr] <= rx_if.data;
    end
  end

  assign tx_if.send    = send_q;
  assign tx_if.crc_en  = crc_en_q;
  assign tx_if.nbytes  = nbytes_q;
  assign tx_if.rd_data = tx_rd_q;
  assign rx_if.busy    = rcvd_q;
  assign inta_o        = rcvd_q;

endmodule

//--- hw/eth_tx_fsm.sv
`timescale 1ns/100ps
`include "eth_cfg.svh"

module eth_tx_fsm (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       phy_rst_i,
  output logic [3:0] mii_txd_o,
  output logic       mii_tx_en_o,
  eth_tx_if.tx       tx_if
);

  eth_pkg::tx_state_e  state_q;
  logic [3:0]          nib_cnt_q;  // Preamble and FCS index, bit 0 is the data phase
  logic [`ETH_BUF_W:0] byte_cnt_q;
  logic [`ETH_BUF_W:0] nbytes_q;   // Latched at start of frame
  logic                crc_en_q;
  logic [31:0]         crc_q;
  logic [3:0]          nib;
  logic                last_byte;

  assign tx_if.ready = (state_q == eth_pkg::TX_IDLE) && !phy_rst_i;

  // Next byte is requested during the high nibble of the current one
  assign tx_if.rd_addr = (state_q == eth_pkg::TX_DATA && nib_cnt_q[0]) ?
                         byte_cnt_q[`ETH_BUF_W-1:0] + 1'b1 :
                         byte_cnt_q[`ETH_BUF_W-1:0];

  assign last_byte = (byte_cnt_q == nbytes_q - 1'b1);

  always_comb begin
    case (state_q)
      eth_pkg::TX_PREAMBLE:
        nib = (nib_cnt_q == 4'd15) ? eth_pkg::SFD_NIB : eth_pkg::PREAMBLE_NIB;
      eth_pkg::TX_DATA:
        nib = nib_cnt_q[0] ? tx_if.rd_data[7:4] : tx_if.rd_data[3:0]; // Low nibble first
      eth_pkg::TX_FCS:
        nib = ~crc_q[3:0];
      default:
        nib = 4'h0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= eth_pkg::TX_IDLE;
      nib_cnt_q   <= '0;
      byte_cnt_q  <= '0;
      nbytes_q    <= '0;
      crc_en_q    <= 1'b0;
      crc_q       <= eth_pkg::CRC_INIT;
      mii_txd_o   <= 4'h0;
      mii_tx_en_o <= 1'b0;
    end else begin
      mii_txd_o   <= nib;
      mii_tx_en_o <= (state_q != eth_pkg::TX_IDLE);
      case (state_q)
        eth_pkg::TX_IDLE: begin
          if (tx_if.send && tx_if.ready) begin
            state_q    <= eth_pkg::TX_PREAMBLE;
            nib_cnt_q  <= '0;
            byte_cnt_q <= '0;
            nbytes_q   <= tx_if.nbytes;
            crc_en_q   <= tx_if.crc_en;
            crc_q      <= eth_pkg::CRC_INIT;
          end
        end
        eth_pkg::TX_PREAMBLE: begin
          nib_cnt_q <= nib_cnt_q + 1'b1; // Wraps to 0 for the data phase
          if (nib_cnt_q == 4'd15) begin
            if (nbytes_q != '0) begin
              state_q <= eth_pkg::TX_DATA;
            end else if (crc_en_q) begin
              state_q <= eth_pkg::TX_FCS;
            end else begin
              state_q <= eth_pkg::TX_IDLE;
            end
          end
        end
        eth_pkg::TX_DATA: begin
          crc_q     <= eth_pkg::crc32_nibble(crc_q, nib);
          nib_cnt_q <= {3'b000, ~nib_cnt_q[0]};
          if (nib_cnt_q[0]) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (last_byte) begin
              state_q <= crc_en_q ? eth_pkg::TX_FCS : eth_pkg::TX_IDLE;
            end
          end
        end
        eth_pkg::TX_FCS: begin
          crc_q     <= {4'h0, crc_q[31:4]};
          nib_cnt_q <= nib_cnt_q + 1'b1;
          if (nib_cnt_q == 4'd7) begin
            state_q <= eth_pkg::TX_IDLE;
          end
        end
        default: state_q <= eth_pkg::TX_IDLE;
      endcase
    end
  end

endmodule

//--- hw/eth_rx.sv
`timescale 1ns/100ps
`include "eth_cfg.svh"

module eth_rx (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       phy_rst_i,
  input  logic [3:0] mii_rxd_i,
  input  logic       mii_rx_dv_i,
  eth_rx_if.rx       rx_if
);

  eth_pkg::rx_state_e    state_q;
  logic                  hi_q;       // Next nibble is the upper half
  logic [3:0]            lo_q;
  logic [`ETH_BUF_W:0]   cnt_q;      // Saturates at the buffer size
  logic [31:0]           crc_q;
  logic [31:0]           crc_rev;
  logic                  wr_q;
  logic [`ETH_BUF_W-1:0] addr_q;
  logic [7:0]            data_q;
  logic                  done_q;

  assign crc_rev = {<<{crc_q}};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= eth_pkg::RX_IDLE;
      hi_q    <= 1'b0;
      cnt_q   <= '0;
      crc_q   <= eth_pkg::CRC_INIT;
      wr_q    <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      wr_q   <= 1'b0;
      done_q <= 1'b0;
      case (state_q)
        eth_pkg::RX_IDLE: begin
          if (mii_rx_dv_i) begin
            // Frames arriving while busy or in PHY reset are drained
            if (!rx_if.busy && !phy_rst_i && mii_rxd_i == eth_pkg::PREAMBLE_NIB) begin
              state_q <= eth_pkg::RX_PREAMBLE;
            end else begin
              state_q <= eth_pkg::RX_DONE;
            end
          end
        end
        eth_pkg::RX_PREAMBLE: begin
          if (!mii_rx_dv_i) begin
            state_q <= eth_pkg::RX_IDLE;
          end else if (mii_rxd_i == eth_pkg::SFD_NIB) begin
            state_q <= eth_pkg::RX_DATA;
            hi_q    <= 1'b0;
            cnt_q   <= '0;
            crc_q   <= eth_pkg::CRC_INIT;
          end else if (mii_rxd_i != eth_pkg::PREAMBLE_NIB) begin
            state_q <= eth_pkg::RX_DONE;
          end
        end
        eth_pkg::RX_DATA: begin
          if (mii_rx_dv_i) begin
            crc_q <= eth_pkg::crc32_nibble(crc_q, mii_rxd_i); // FCS included
            hi_q  <= ~hi_q;
            if (!hi_q) begin
              lo_q <= mii_rxd_i;
            end else begin
              wr_q   <= ~cnt_q[`ETH_BUF_W]; // Drop bytes past the buffer
              addr_q <= cnt_q[`ETH_BUF_W-1:0];
              data_q <= {mii_rxd_i, lo_q};
              if (!cnt_q[`ETH_BUF_W]) begin
                cnt_q <= cnt_q + 1'b1;
              end
            end
          end else begin
            done_q  <= 1'b1;
            state_q <= eth_pkg::RX_IDLE;
          end
        end
        eth_pkg::RX_DONE: begin
          if (!mii_rx_dv_i) begin
            state_q <= eth_pkg::RX_IDLE;
          end
        end
        default: state_q <= eth_pkg::RX_IDLE;
      endcase
    end
  end

  assign rx_if.wr      = wr_q;
  assign rx_if.addr    = addr_q;
  assign rx_if.data    = data_q;
  assign rx_if.done    = done_q;
  assign rx_if.nbytes  = cnt_q;   // Stable while done is high
  assign rx_if.crc_err = (crc_rev != eth_pkg::CRC_RESIDUE);

endmodule

//--- hw/eth_phy_rst_timer.sv
`timescale 1ns/100ps
`include "eth_cfg.svh"

module eth_phy_rst_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic phy_rst_o
);

  localparam logic [`ETH_PHY_RST_W-1:0] RST_CNT = `ETH_PHY_RST_CNT;

  logic [`ETH_PHY_RST_W-1:0] cnt_q;

  // Counts down once after system reset, then parks at zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= RST_CNT;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign phy_rst_o = (cnt_q != '0);

endmodule

//--- hw/eth_core.sv
`timescale 1ns/100ps

module eth_core (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Wishbone classic slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [8:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  // MII, one nibble per clk_i
  output logic [3:0]  mii_txd_o,
  output logic        mii_tx_en_o,
  input  logic [3:0]  mii_rxd_i,
  input  logic        mii_rx_dv_i,
  output logic        phy_rstn_o,
  output logic        inta_o
);

  logic phy_rst;

  eth_tx_if tx_if ();
  eth_rx_if rx_if ();

  eth_phy_rst_timer u_phy_rst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .phy_rst_o (phy_rst)
  );

  assign phy_rstn_o = ~phy_rst;

  eth_wb_regs u_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .inta_o    (inta_o),
    .phy_rst_i (phy_rst),
    .tx_if     (tx_if.regs),
    .rx_if     (rx_if.regs)
  );

  eth_tx_fsm u_tx (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .phy_rst_i   (phy_rst),
    .mii_txd_o   (mii_txd_o),
    .mii_tx_en_o (mii_tx_en_o),
    .tx_if       (tx_if.tx)
  );

  eth_rx u_rx (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .phy_rst_i   (phy_rst),
    .mii_rxd_i   (mii_rxd_i),
    .mii_rx_dv_i (mii_rx_dv_i),
    .rx_if       (rx_if.rx)
  );

endmodule

//--- tb/eth_core_tb.sv
`timescale 1ns/100ps
`include "eth_cfg.svh"

module eth_core_tb;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [8:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic [3:0]  mii_txd_o;
  logic        mii_tx_en_o;
  logic [3:0]  mii_rxd_i = 4'h0;
  logic        mii_rx_dv_i = 1'b0;
  logic        phy_rstn_o;
  logic        inta_o;

  logic [31:0] lcg_state = 32'h1464;
  logic [7:0]  sb [64];      // Bytes last loaded into the tx buffer
  logic [7:0]  rx_exp [$];   // Expected rx buffer contents
  logic [3:0]  tx_nibs [$];  // Nibbles of the current tx burst
  int          tx_bursts = 0;
  int          burst_base = 0;
  logic        en_prev = 1'b0;
  logic [3:0]  smp_d = 4'h0;
  logic        smp_v = 1'b0;
  logic [3:0]  inj_d = 4'h0;
  logic        inj_v = 1'b0;
  logic        loop_en = 1'b1;  // Loopback or injected nibbles
  int          lens [5];
  int          wd_cycles = 0;

  eth_core dut (.*);

  always #5 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_failure($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else report_failure(what);
  endtask

  assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_ack_o |=> !wb_ack_o)
    else report_failure("wb_ack_o stayed high for more than one cycle");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $rose(wb_cyc_i && wb_stb_i) |=> wb_ack_o)
    else report_failure("wb_ack_o missing one cycle after the strobe");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else report_failure("wb_ack_o without a strobe");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) phy_rstn_o |=> phy_rstn_o)
    else report_failure("phy_rstn_o fell again after the PHY reset ended");
  assert property (@(posedge clk_i) !phy_rstn_o |-> !mii_tx_en_o)
    else report_failure("mii_tx_en_o high while the PHY is in reset");

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bits 22:16 carry a length, bits 1:0 the flags
  function automatic logic [31:0] pack_len_word(input int n, input logic b1);
    return {9'h0, 7'(n), 14'h0, b1, 1'b1};
  endfunction

  // Reference Ethernet FCS, byte-wise and LSB first
  function automatic logic [31:0] frame_fcs(input int n);
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    for (int i = 0; i < n; i++) begin
      crc ^= {24'h0, sb[i]};
      for (int b = 0; b < 8; b++) begin
        crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
    end
    return ~crc;
  endfunction

  // Monitor and loopback register, sampled away from the rising edge
  always @(negedge clk_i) begin
    if (mii_tx_en_o) tx_nibs.push_back(mii_txd_o);
    if (en_prev && !mii_tx_en_o) tx_bursts++;
    en_prev = mii_tx_en_o;
    smp_d = mii_txd_o;
    smp_v = mii_tx_en_o;
  end

  always @(posedge clk_i) begin
    #1;
    mii_rxd_i   = loop_en ? smp_d : inj_d;
    mii_rx_dv_i = loop_en ? smp_v : inj_v;
  end

  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk_i);
    report_failure($sformatf("Timeout after %0d cycles, the test did not finish", wd_cycles));
  end

  task automatic wb_access(input logic we, input logic [8:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(negedge clk_i);
    while (!wb_ack_o) @(negedge clk_i);
    rdat = wb_dat_o; // Valid with ack
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [8:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [8:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'h0, dat);
  endtask

  task automatic fill_sb(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      sb[i] = r[23:16];
    end
  endtask

  task automatic load_tx(input int n);
    fill_sb(n);
    for (int i = 0; i < n; i++) begin
      wb_write(eth_pkg::REG_BUF_BASE + 9'(4 * i), {24'h0, sb[i]});
    end
  endtask

  task automatic start_tx(input int n, input logic crc_en);
    tx_nibs.delete();
    burst_base = tx_bursts;
    wb_write(eth_pkg::REG_TX_CTRL, pack_len_word(n, crc_en));
    @(negedge clk_i);
    check_eq("mii_tx_en_o one cycle after ack", mii_tx_en_o, 0);
    @(negedge clk_i);
    check_eq("mii_tx_en_o two cycles after ack", mii_tx_en_o, 1);
  endtask

  task automatic wait_tx_done();
    while (tx_bursts == burst_base) @(posedge clk_i);
  endtask

  task automatic check_tx_burst(input int n, input logic crc_en);
    logic [31:0] fcs;
    int          base;
    check_eq("mii_tx_en_o burst length", tx_nibs.size(), crc_en ? 2 * (12 + n) : 2 * (8 + n));
    for (int i = 0; i < 16; i++) begin
      check_eq("mii_txd_o preamble", tx_nibs[i], (i == 15) ? 4'hD : 4'h5);
    end
    for (int i = 0; i < n; i++) begin
      check_eq("mii_txd_o data low", tx_nibs[16 + 2 * i], sb[i][3:0]);
      check_eq("mii_txd_o data high", tx_nibs[17 + 2 * i], sb[i][7:4]);
    end
    if (crc_en) begin
      fcs  = frame_fcs(n);
      base = 16 + 2 * n;
      for (int k = 0; k < 8; k++) begin
        check_eq("mii_txd_o FCS", tx_nibs[base + k], fcs[4 * k +: 4]);
      end
    end
  endtask

  task automatic set_rx_exp(input int n, input logic with_fcs);
    logic [31:0] fcs;
    fcs = frame_fcs(n);
    rx_exp.delete();
    for (int i = 0; i < n; i++) rx_exp.push_back(sb[i]);
    if (with_fcs) begin
      for (int k = 0; k < 4; k++) rx_exp.push_back(fcs[8 * k +: 8]);
    end
  endtask

  // Wire bytes come from rx_exp, low nibble first
  task automatic inject_frame();
    loop_en = 1'b0;
    for (int i = 0; i < 16 + 2 * rx_exp.size(); i++) begin
      @(posedge clk_i);
      inj_v = 1'b1;
      if (i < 16) inj_d = (i == 15) ? 4'hD : 4'h5;
      else inj_d = rx_exp[(i - 16) / 2][4 * (i % 2) +: 4];
    end
    @(posedge clk_i);
    inj_v = 1'b0;
  endtask

  task automatic wait_rx_flag();
    int cycles;
    cycles = 0;
    while (!inta_o && cycles < 8) begin
      @(negedge clk_i);
      cycles++;
    end
    check_true(inta_o, "inta_o did not rise after the received frame ended");
  endtask

  task automatic check_rx(input int nb, input logic err);
    logic [31:0] d;
    wb_read(eth_pkg::REG_RX_STAT, d);
    check_eq("wb_dat_o RX_STAT", d, pack_len_word(nb, err));
    for (int i = 0; i < rx_exp.size(); i++) begin
      wb_read(eth_pkg::REG_BUF_BASE + 9'(4 * i), d);
      check_eq("wb_dat_o rx buffer", d, {24'h0, rx_exp[i]});
    end
  endtask

  initial begin
    logic [31:0] d;
    logic [31:0] r;
    int          phy_low;
    int          n;
    int          flip;
    rst_n_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    for (int i = 0; i < 5; i++) begin
      r = lcg_next();
      lens[i] = 8 + int'(r[15:8] % 40);
    end
    wd_cycles = 40 * (lens[0] + lens[1] + lens[2] + lens[3] + lens[4]) + 2000;
    repeat (10) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    check_eq("wb_ack_o", wb_ack_o, 0);
    check_eq("mii_tx_en_o", mii_tx_en_o, 0);
    check_eq("inta_o", inta_o, 0);

    // PHY reset window, with a send that must be ignored
    phy_low = 0;
    fork
      begin
        @(negedge clk_i);
        while (!phy_rstn_o) begin
          phy_low++;
          @(negedge clk_i);
        end
      end
      begin
        wb_read(eth_pkg::REG_PHY_STAT, d);
        check_eq("wb_dat_o PHY_STAT", d, 1);
        wb_read(eth_pkg::REG_TX_CTRL, d);
        check_eq("wb_dat_o TX_CTRL", d, 0);
        wb_write(eth_pkg::REG_TX_CTRL, pack_len_word(8, 1'b1));
      end
    join
    check_eq("phy_rstn_o low cycles", phy_low, `ETH_PHY_RST_CNT);
    wb_read(eth_pkg::REG_PHY_STAT, d);
    check_eq("wb_dat_o PHY_STAT", d, 0);
    wb_read(eth_pkg::REG_TX_CTRL, d);
    check_eq("wb_dat_o TX_CTRL", d, 1);

    // Good frame over the loopback
    n = lens[0];
    load_tx(n);
    start_tx(n, 1'b1);
    wait_tx_done();
    check_tx_burst(n, 1'b1);
    set_rx_exp(n, 1'b1);
    wait_rx_flag();
    check_rx(n + 4, 1'b0);
    wb_write(eth_pkg::REG_RX_STAT, 32'h0);
    check_true(!inta_o, "inta_o still high after the acknowledge");

    // No FCS appended, so the receiver flags a CRC error
    n = lens[1];
    load_tx(n);
    start_tx(n, 1'b0);
    wait_tx_done();
    check_tx_burst(n, 1'b0);
    set_rx_exp(n, 1'b0);
    wait_rx_flag();
    check_rx(n, 1'b1);

    // Second frame before the acknowledge is dropped
    n = lens[2];
    load_tx(n);
    start_tx(n, 1'b1);
    wait_tx_done();
    check_tx_burst(n, 1'b1);
    repeat (8) @(posedge clk_i);
    check_true(inta_o, "inta_o dropped while a frame was pending");
    check_rx(lens[1], 1'b1);
    wb_write(eth_pkg::REG_RX_STAT, 32'h0);
    check_true(!inta_o, "inta_o still high after the acknowledge");

    // Injected frame with one flipped nibble
    n = lens[3];
    fill_sb(n);
    set_rx_exp(n, 1'b1);
    r = lcg_next();
    flip = int'(r[15:8] % (2 * n));
    rx_exp[flip / 2] ^= (flip % 2) ? 8'h10 : 8'h01;
    inject_frame();
    wait_rx_flag();
    loop_en = 1'b1;
    check_rx(n + 4, 1'b1);
    wb_write(eth_pkg::REG_RX_STAT, 32'h0);

    // Send written during a burst
    n = lens[4];
    load_tx(n);
    start_tx(n, 1'b1);
    while (tx_nibs.size() < 8) @(posedge clk_i);
    wb_read(eth_pkg::REG_TX_CTRL, d);
    check_eq("wb_dat_o TX_CTRL busy", d, 0);
    wb_write(eth_pkg::REG_TX_CTRL, pack_len_word(n, 1'b1));
    wait_tx_done();
    check_tx_burst(n, 1'b1);
    repeat (12) @(posedge clk_i);
    check_eq("mii_tx_en_o burst count", tx_bursts, burst_base + 1);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/eth_pkg.sv
hw/eth_if.sv
hw/eth_wb_regs.sv
hw/eth_tx_fsm.sv
hw/eth_rx.sv
hw/eth_phy_rst_timer.sv
hw/eth_core.sv
tb/eth_core_tb.sv

//--- Bender.yml
package:
  name: eth_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/eth_pkg.sv
      - hw/eth_if.sv
      - hw/eth_wb_regs.sv
      - hw/eth_tx_fsm.sv
      - hw/eth_rx.sv
      - hw/eth_phy_rst_timer.sv
      - hw/eth_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/eth_core_tb.sv
